/* hw/decodeCtrl.sv */
`include "fetch_cfg.svh"

module decodeCtrl (
    input  logic             rst,
    input  fetchPkg::instr_t rawInstr,
    input  logic             insertNop,
    output fetchPkg::instr_t instrOut,
    output logic             regWrite,
    output logic [2:0]       writeRegAddr,
    output logic             memEnable,
    output logic             memWr,
    output logic             val2Reg,
    output logic             aluSel,
    output logic [2:0]       immSel,
    output logic [1:0]       linkReg,
    output logic             bFlag,
    output logic             jFlag,
    output logic             regJmp,
    output logic             halt,
    output logic             ctrlErr,
    output logic             usesRs,
    output logic             usesRt
);
    import fetchPkg::*;

    opcode_t  opcode;
    opcode_t  rawOp;
    destSel_t destSel;

    // Bubble while in reset and on a load-use stall
    assign instrOut = (rst || insertNop) ? instr_t'(`NOP_INSTR) : rawInstr;
    assign opcode   = opcode_t'(instrOut[15:11]);
    assign rawOp    = opcode_t'(rawInstr[15:11]);

    // immSel 001 is 5-bit signed, 010 is 8-bit signed, 100 is 11-bit displacement
    always_comb begin
        regWrite  = 1'b0;
        destSel   = DEST_RD_R;
        memEnable = 1'b0;
        memWr     = 1'b0;
        val2Reg   = 1'b0;
        aluSel    = 1'b0;
        immSel    = 3'b000;
        linkReg   = 2'b00;
        bFlag     = 1'b0;
        jFlag     = 1'b0;
        regJmp    = 1'b0;
        halt      = 1'b0;
        ctrlErr   = 1'b0;
        case (opcode)
            HALT: halt = 1'b1;
            NOP: ;
            J: begin
                jFlag  = 1'b1;
                immSel = 3'b100;
            end
            JR: begin
                regJmp = 1'b1;          // Target is rs plus imm
                immSel = 3'b010;
            end
            JAL: begin
                jFlag    = 1'b1;
                immSel   = 3'b100;
                regWrite = 1'b1;
                destSel  = DEST_R7;
                linkReg  = 2'b01;       // Write back PC+2
            end
            JALR: begin
                regJmp   = 1'b1;
                immSel   = 3'b010;
                regWrite = 1'b1;
                destSel  = DEST_R7;
                linkReg  = 2'b01;
            end
            ADDI: begin
                regWrite = 1'b1;
                destSel  = DEST_RD_I;
                aluSel   = 1'b1;        // Immediate operand
                immSel   = 3'b001;
            end
            BEQZ: begin
                bFlag  = 1'b1;
                immSel = 3'b010;
            end
            ST: begin
                memEnable = 1'b1;
                memWr     = 1'b1;
                aluSel    = 1'b1;
                immSel    = 3'b001;
            end
            LD: begin
                memEnable = 1'b1;
                regWrite  = 1'b1;
                destSel   = DEST_RD_I;
                val2Reg   = 1'b1;       // Memory data to register
                aluSel    = 1'b1;
                immSel    = 3'b001;
            end
            ALU_R: begin
                regWrite = 1'b1;
                destSel  = DEST_RD_R;
            end
            default: ctrlErr = 1'b1;
        endcase
    end

    always_comb begin
        case (destSel)
            DEST_RS:   writeRegAddr = instrOut[10:8];
            DEST_RD_R: writeRegAddr = instrOut[4:2];
            DEST_R7:   writeRegAddr = `LINK_REG;
            DEST_RD_I: writeRegAddr = instrOut[7:5];
            default:   writeRegAddr = instrOut[4:2];
        endcase
    end

    // Taken from the raw word so the hazard check never sees its own bubble
    always_comb begin
        usesRs = 1'b0;
        usesRt = 1'b0;
        case (rawOp)
            ADDI, BEQZ, LD, JR, JALR: usesRs = 1'b1;
            ST, ALU_R: begin
                usesRs = 1'b1;
                usesRt = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hw/fetchPkg.sv */
`include "fetch_cfg.svh"

package fetchPkg;

    typedef logic [`FETCH_ADDR_W-1:0] addr_t;   // Byte address, halfword aligned
    typedef logic [15:0]              instr_t;

    // Instruction bits 15..11
    typedef enum logic [4:0] {
        HALT  = 5'b00000,
        NOP   = 5'b00001,
        J     = 5'b00100,
        JR    = 5'b00101,
        JAL   = 5'b00110,
        JALR  = 5'b00111,
        ADDI  = 5'b01000,
        BEQZ  = 5'b01100,
        ST    = 5'b10000,
        LD    = 5'b10001,
        ALU_R = 5'b11011
    } opcode_t;

    // Which field names the register to write
    typedef enum logic [1:0] {
        DEST_RS   = 2'b00,  // Bits 10..8
        DEST_RD_R = 2'b01,  // Bits 4..2
        DEST_R7   = 2'b10,  // Link register
        DEST_RD_I = 2'b11   // Bits 7..5
    } destSel_t;

endpackage

/* hw/fetchStage.sv */
`include "fetch_cfg.svh"

module fetchStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             loadEn,
    input  fetchPkg::addr_t  loadAddr,
    input  fetchPkg::instr_t loadData,
    input  logic             pcSel,
    input  fetchPkg::addr_t  brnchAddr,
    input  fetchPkg::addr_t  rs,
    input  fetchPkg::addr_t  imm,
    output fetchPkg::addr_t  pc,
    output fetchPkg::instr_t instrOut,
    output logic             regWrite,
    output logic [2:0]       writeRegAddr,
    output logic             memEnable,
    output logic             memWr,
    output logic             val2Reg,
    output logic             aluSel,
    output logic [2:0]       immSel,
    output logic [1:0]       linkReg,
    output logic             bFlag,
    output logic             jFlag,
    output logic             halt,
    output logic             ctrlErr
);
    import fetchPkg::*;

    instr_t rawInstr;
    logic   insertNop;
    logic   regJmp;
    logic   usesRs;
    logic   usesRt;

    progCounter pcReg (
        .clk       (clk),
        .rst       (rst),
        .pcSel     (pcSel),
        .brnchAddr (brnchAddr),
        .rs        (rs),
        .imm       (imm),
        .regJmp    (regJmp),
        .halt      (halt),
        .stall     (insertNop),     // Hold PC for the bubble
        .pc        (pc)
    );

    instrMem imem (
        .clk      (clk),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .readAddr (pc[$clog2(`IMEM_DEPTH):1]),  // Word index
        .readData (rawInstr)
    );

    decodeCtrl decoder (
        .rst          (rst),
        .rawInstr     (rawInstr),
        .insertNop    (insertNop),
        .instrOut     (instrOut),
        .regWrite     (regWrite),
        .writeRegAddr (writeRegAddr),
        .memEnable    (memEnable),
        .memWr        (memWr),
        .val2Reg      (val2Reg),
        .aluSel       (aluSel),
        .immSel       (immSel),
        .linkReg      (linkReg),
        .bFlag        (bFlag),
        .jFlag        (jFlag),
        .regJmp       (regJmp),
        .halt         (halt),
        .ctrlErr      (ctrlErr),
        .usesRs       (usesRs),
        .usesRt       (usesRt)
    );

    hazardDetect hazard (
        .clk       (clk),
        .rst       (rst),
        .rawInstr  (rawInstr),
        .usesRs    (usesRs),
        .usesRt    (usesRt),
        .insertNop (insertNop)
    );

endmodule

/* hw/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// PC, branch target and jump operand width
`define FETCH_ADDR_W 16

// Instruction memory size in 16-bit words
`define IMEM_DEPTH   256

// Opcode 00001 with all other fields zero
`define NOP_INSTR    16'h0800

`define LINK_REG     3'd7      // JAL and JALR write R7

`endif

/* hw/hazardDetect.sv */
module hazardDetect (
    input  logic             clk,
    input  logic             rst,
    input  fetchPkg::instr_t rawInstr,
    input  logic             usesRs,
    input  logic             usesRt,
    output logic             insertNop
);
    import fetchPkg::*;

    opcode_t    rawOp;
    logic       loadIssue;
    logic       loadValid;
    logic [2:0] loadDest;
    logic       rsHit;
    logic       rtHit;

    assign rawOp = opcode_t'(rawInstr[15:11]);

    assign rsHit     = usesRs && (rawInstr[10:8] == loadDest);
    assign rtHit     = usesRt && (rawInstr[7:5] == loadDest);
    assign insertNop = loadValid && (rsHit || rtHit);

    // A stalled slot issues as NOP, so it never counts as a load
    assign loadIssue = !insertNop && (rawOp == LD);

    always_ff @(posedge clk) begin
        if (rst) begin
            loadValid <= 1'b0;
        end else begin
            loadValid <= loadIssue;     // Anything else clears the record
        end
    end

    always_ff @(posedge clk) begin
        if (loadIssue) begin
            loadDest <= rawInstr[7:5];  // Rd-I field of LD
        end
    end

endmodule

/* hw/instrMem.sv */
`include "fetch_cfg.svh"

module instrMem (
    input  logic                           clk,
    input  logic                           loadEn,
    input  logic [`FETCH_ADDR_W-1:0]       loadAddr,
    input  logic [15:0]                    loadData,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] readAddr,
    output logic [15:0]                    readData
);
    localparam int idxWidth = $clog2(`IMEM_DEPTH);

    logic [15:0] mem [`IMEM_DEPTH];

    // Word index, one word per strobe
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr[idxWidth-1:0]] <= loadData;
        end
    end

    assign readData = mem[readAddr];    // Same-cycle read for fetch

    // Upper address bits are dropped on write
    loadInRange: assert property (@(posedge clk) loadEn |-> (loadAddr < `IMEM_DEPTH))
        else $error("load address %h beyond memory", loadAddr);

endmodule

/* hw/progCounter.sv */
module progCounter (
    input  logic            clk,
    input  logic            rst,
    input  logic            pcSel,
    input  fetchPkg::addr_t brnchAddr,
    input  fetchPkg::addr_t rs,
    input  fetchPkg::addr_t imm,
    input  logic            regJmp,
    input  logic            halt,
    input  logic            stall,
    output fetchPkg::addr_t pc
);
    import fetchPkg::*;

    addr_t nextPc;
    addr_t seqPc;
    addr_t jmpPc;

    assign seqPc = pc + addr_t'(2);     // Next halfword
    assign jmpPc = rs + imm;            // JR / JALR target

    // A redirect from later stages overrides a local stall
    always_comb begin
        if (pcSel) begin
            nextPc = brnchAddr;
        end else if (stall) begin
            nextPc = pc;                // Load-use bubble
        end else if (halt) begin
            nextPc = pc;
        end else if (regJmp) begin
            nextPc = jmpPc;
        end else begin
            nextPc = seqPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // Targets come from outside this stage and must stay aligned as well
    pcEven: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
        else $error("pc is odd: %h", pc);

endmodule

/* list.f */
+incdir+hw
hw/fetchPkg.sv
hw/progCounter.sv
hw/instrMem.sv
hw/decodeCtrl.sv
hw/hazardDetect.sv
hw/fetchStage.sv
testbench/fetchClock.sv
testbench/fetchTb.sv

/* run.sh */
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module fetchTb \
    -o fetchSim && ./obj_dir/fetchSim > sim.log 2>&1
grep -qx '>>> PASS' sim.log && echo "fetch stage simulation passed" \
    || { echo "fetch stage simulation failed, see sim.log"; exit 1; }

/* testbench/fetchClock.sv */
module fetchClock #(
    parameter int periodNs = 20
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // Starts low, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2) clk = ~clk;
        end
    end

endmodule

/* testbench/fetchTb.sv */
`include "fetch_cfg.svh"

module fetchTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    periodNs  = 20;
    localparam int    minReset  = 8;
    localparam string inputFile = "testbench/fetch_input.txt";

    logic                     clk;
    logic                     rst;
    logic                     loadEn;
    logic [`FETCH_ADDR_W-1:0] loadAddr;
    logic [15:0]              loadData;
    logic                     pcSel;
    logic [`FETCH_ADDR_W-1:0] brnchAddr;
    logic [`FETCH_ADDR_W-1:0] rs;
    logic [`FETCH_ADDR_W-1:0] imm;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [15:0]              instrOut;
    logic                     regWrite;
    logic [2:0]               writeRegAddr;
    logic                     memEnable;
    logic                     memWr;
    logic                     val2Reg;
    logic                     aluSel;
    logic [2:0]               immSel;
    logic [1:0]               linkReg;
    logic                     bFlag;
    logic                     jFlag;
    logic                     halt;
    logic                     ctrlErr;

    // Program image, word index and data
    logic [15:0] progAddr [$];
    logic [15:0] progWord [$];

    // One entry per checked cycle
    logic [15:0] stimSel [$];
    logic [15:0] stimBranch [$];
    logic [15:0] stimRs [$];
    logic [15:0] stimImm [$];
    logic [15:0] expPc [$];
    logic [15:0] expInstr [$];
    logic [15:0] expRegWrite [$];
    logic [15:0] expWriteReg [$];
    logic [15:0] expHalt [$];
    logic [15:0] expCtrlErr [$];

    int resetCycles;
    bit stimReady;

    fetchClock #(.periodNs(periodNs)) clkGen (.clk(clk));

    fetchStage dut_i (
        .clk          (clk),
        .rst          (rst),
        .loadEn       (loadEn),
        .loadAddr     (loadAddr),
        .loadData     (loadData),
        .pcSel        (pcSel),
        .brnchAddr    (brnchAddr),
        .rs           (rs),
        .imm          (imm),
        .pc           (pc),
        .instrOut     (instrOut),
        .regWrite     (regWrite),
        .writeRegAddr (writeRegAddr),
        .memEnable    (memEnable),
        .memWr        (memWr),
        .val2Reg      (val2Reg),
        .aluSel       (aluSel),
        .immSel       (immSel),
        .linkReg      (linkReg),
        .bFlag        (bFlag),
        .jFlag        (jFlag),
        .halt         (halt),
        .ctrlErr      (ctrlErr)
    );

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // LD (10001) and ST (10000) enable memory, only ST writes
    task automatic verifyMemControls(input logic [15:0] instr);
        logic expEnable;
        logic expWrite;
        expEnable = (instr[15:11] == 5'b10001) || (instr[15:11] == 5'b10000);
        expWrite  = (instr[15:11] == 5'b10000);
        checkValue("memEnable", 16'(memEnable), 16'(expEnable));
        checkValue("memWr", 16'(memWr), 16'(expWrite));
    endtask

    // Bubble word with every control inactive
    task automatic expectNopControls();
        checkValue("instrOut", instrOut, `NOP_INSTR);
        checkValue("regWrite", 16'(regWrite), 16'h0000);
        checkValue("memEnable", 16'(memEnable), 16'h0000);
        checkValue("memWr", 16'(memWr), 16'h0000);
        checkValue("val2Reg", 16'(val2Reg), 16'h0000);
        checkValue("aluSel", 16'(aluSel), 16'h0000);
        checkValue("immSel", 16'(immSel), 16'h0000);
        checkValue("linkReg", 16'(linkReg), 16'h0000);
        checkValue("bFlag", 16'(bFlag), 16'h0000);
        checkValue("jFlag", 16'(jFlag), 16'h0000);
        checkValue("halt", 16'(halt), 16'h0000);
        checkValue("ctrlErr", 16'(ctrlErr), 16'h0000);
    endtask

    task automatic reportBadLine(input string line);
        $display("Stimulus file has a line that cannot be parsed: %s", line);
        $display(">>> FAIL");
        $fatal(1, "bad stimulus line");
    endtask

    // P lines hold program words, C lines hold one cycle each
    task automatic readStimulus();
        int          fd;
        int          count;
        string       line;
        logic [15:0] vAddr, vWord;
        logic [15:0] vSel, vBranch, vRs, vImm, vPc, vInstr, vRw, vWra, vHalt, vErr;
        fd = $fopen(inputFile, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", inputFile);
            $display(">>> FAIL");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            if (count == 0 || line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;               // Blank or comment
            end
            if (line[0] == "P") begin
                count = $sscanf(line, "P %h %h", vAddr, vWord);
                if (count != 2) reportBadLine(line);
                progAddr.push_back(vAddr);
                progWord.push_back(vWord);
            end else if (line[0] == "C") begin
                count = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h", vSel, vBranch,
                                vRs, vImm, vPc, vInstr, vRw, vWra, vHalt, vErr);
                if (count != 10) reportBadLine(line);
                stimSel.push_back(vSel);
                stimBranch.push_back(vBranch);
                stimRs.push_back(vRs);
                stimImm.push_back(vImm);
                expPc.push_back(vPc);
                expInstr.push_back(vInstr);
                expRegWrite.push_back(vRw);
                expWriteReg.push_back(vWra);
                expHalt.push_back(vHalt);
                expCtrlErr.push_back(vErr);
            end else begin
                reportBadLine(line);
            end
        end
        $fclose(fd);
        if (stimSel.size() == 0) begin
            $display("Stimulus file holds no cycle lines");
            $display(">>> FAIL");
            $fatal(1, "empty stimulus");
        end
    endtask

    // One program word per cycle while reset is high
    task automatic resetAndLoad();
        int i;
        wait (clk === 1'b0);
        for (i = 0; i < resetCycles; i++) begin
            if (i < progWord.size()) begin
                loadEn   = 1'b1;
                loadAddr = progAddr[i];
                loadData = progWord[i];
            end else begin
                loadEn = 1'b0;
            end
            #(periodNs / 2 - 1);
            expectNopControls();        // Reset forces the bubble
            @(negedge clk);
        end
        loadEn = 1'b0;
        rst    = 1'b0;
    endtask

    task automatic runCycles();
        int c;
        for (c = 0; c < stimSel.size(); c++) begin
            pcSel     = stimSel[c][0];
            brnchAddr = stimBranch[c];
            rs        = stimRs[c];
            imm       = stimImm[c];
            #(periodNs / 2 - 1);        // Just before the rising edge
            checkValue("pc", pc, expPc[c]);
            checkValue("instrOut", instrOut, expInstr[c]);
            checkValue("regWrite", 16'(regWrite), expRegWrite[c]);
            // Destination only means something for a writing instruction
            if (expRegWrite[c][0]) begin
                checkValue("writeRegAddr", 16'(writeRegAddr), expWriteReg[c]);
            end
            checkValue("halt", 16'(halt), expHalt[c]);
            checkValue("ctrlErr", 16'(ctrlErr), expCtrlErr[c]);
            verifyMemControls(expInstr[c]);
            if (expInstr[c] === `NOP_INSTR) begin
                expectNopControls();
            end
            @(negedge clk);
        end
    endtask

    initial begin
        wait (stimReady);
        #((resetCycles + stimSel.size() + 20) * periodNs);
        $display("Run timed out after %0d cycles", resetCycles + stimSel.size() + 20);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst       = 1'b1;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        pcSel     = 1'b0;
        brnchAddr = '0;
        rs        = '0;
        imm       = '0;
        stimReady = 1'b0;
        readStimulus();
        resetCycles = (progWord.size() > minReset) ? progWord.size() : minReset;
        stimReady = 1'b1;
        resetAndLoad();
        runCycles();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* testbench/fetch_input.txt */
// P wordIndex word   (program image, loaded during reset)
// C pcSel brnchAddr rs imm expPc expInstr expRegWrite expWriteReg expHalt expCtrlErr
// All fields hex; expWriteReg is compared only when expRegWrite is 1

// ALU_R r1,r2 -> r3
P 0 D94C
// ADDI r1 -> r5
P 1 41A3
// LD [r2] -> r4
P 2 8A80
// ALU_R r4,r1 -> r6, reads the load result
P 3 DC38
// JR r3, overridden by the branch redirect
P 4 2B04
// JALR r2 -> link in r7
P 6 3A00
// Illegal opcode 11111
P A F800
// HALT
P B 0000

// Straight-line ALU_R and ADDI
C 0 0000 0000 0000 0000 D94C 1 3 0 0
C 0 0000 0000 0000 0002 41A3 1 5 0 0
// Load then a dependent ALU_R, one bubble with pc held
C 0 0000 0000 0000 0004 8A80 1 4 0 0
C 0 0000 0000 0000 0006 0800 0 0 0 0
C 0 0000 0000 0000 0006 DC38 1 6 0 0
// Branch redirect beats the JR
C 1 000C 0040 0000 0008 2B04 0 0 0 0
// JALR to rs plus imm
C 0 0000 0010 0004 000C 3A00 1 7 0 0
C 0 0000 0000 0000 0014 F800 0 0 0 1
// HALT holds pc from here on
C 0 0000 0000 0000 0016 0000 0 0 1 0
C 0 0000 0000 0000 0016 0000 0 0 1 0
C 0 0000 0000 0000 0016 0000 0 0 1 0
C 0 0000 0000 0000 0016 0000 0 0 1 0
C 0 0000 0000 0000 0016 0000 0 0 1 0
